/* tests/load_queue_vectors.txt */
# dis n rob0 rob1 | res pipe miss rob rd addr mask data | refill rob data merged
# store lq addr mask rob_or_ff | commit n | redirect rob | ready lanes | wb rob0 rob1_or_ff
# nowb cycles | idle cycles | tail lq   (all fields hex)
tail 0
dis 2 00 01
dis 1 02 00
tail 3
commit 2
commit 1
dis 2 03 04
commit 2
dis 2 05 06
commit 2
dis 2 07 08
tail 9
commit 2
dis 2 0a 0b
res 0 0 0a 05 00001000 f 11223344
res 1 1 0b 06 00001004 3 aabbccdd
nowb 4
refill 0b 55667788 5566ccdd
wb 0b ff
nowb 4
commit 2
dis 2 0c 0d
dis 1 0e 00
res 0 1 0c 07 00002000 0 00000000
res 1 1 0d 08 00002004 1 000000ee
res 0 1 0e 09 00002008 f 12345678
ready 0
refill 0c cafef00d cafef00d
refill 0d 01020304 010203ee
nowb 3
ready 3
wb 0c 0d
ready 2
refill 0e 9abcdef0 12345678
nowb 4
ready 3
wb 0e ff
nowb 3
commit 2
commit 1
dis 1 0f 00
dis 2 10 11
res 0 0 0f 0a 00003000 f 00000000
res 1 0 10 0b 00003000 c 00000000
res 0 0 11 0c 00003000 4 00000000
store f 00003000 4 10
store f 00003000 3 ff
store f 00003004 f ff
store 0 00003000 c 11
commit 2
commit 1
store f 00003000 4 ff
idle 2
dis 2 12 13
dis 2 14 15
res 0 1 12 0d 00004000 0 00000000
res 1 1 13 0e 00004004 0 00000000
res 0 1 14 0f 00004008 0 00000000
res 1 1 15 10 0000400c 0 00000000
redirect 13
tail 2
refill 13 aaaaaaaa aaaaaaaa
refill 15 bbbbbbbb bbbbbbbb
nowb 4
refill 12 0000beef 0000beef
wb 12 ff
dis 2 16 17
res 0 1 16 11 00004010 0 00000000
refill 16 00c0ffee 00c0ffee
wb 16 ff
commit 2
res 1 1 17 12 00004014 0 00000000
commit 1
refill 17 22222222 22222222
nowb 4
tail 4

/* all.f */
logic/lsq_pkg.sv
logic/lq_pointers.sv
logic/lq_entries.sv
logic/lq_violation_check.sv
logic/lq_writeback_select.sv
logic/load_queue.sv
tests/load_queue_tb.sv

/* Bender.yml */
package:
  name: load_queue

sources:
  - logic/lsq_pkg.sv
  - logic/lq_pointers.sv
  - logic/lq_entries.sv
  - logic/lq_violation_check.sv
  - logic/lq_writeback_select.sv
  - logic/load_queue.sv
  - target: test
    files:
      - tests/load_queue_tb.sv

/* tests/load_queue_tb.sv */
`default_nettype none

module load_queue_tb import lsq_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    logic clk;
    logic rst;
    dis_req_t dis [DIS_PORTS];
    logic [1:0] dis_num;
    lq_idx_t tail_idx;
    load_res_t res [LOAD_PIPES];
    refill_t refill;
    store_chk_t store_chk;
    logic [1:0] commit_num;
    logic redirect;
    rob_idx_t redirect_rob;
    wb_t wb [LOAD_PIPES];
    logic [LOAD_PIPES-1:0] wb_ready;
    violation_t violation;

    logic [LQ_SIZE-1:0] ref_valid;                  // the reference model keeps one valid bit per slot.
    logic [LQ_SIZE-1:0] ref_exec;
    logic [XLEN-1:0] ref_addr [LQ_SIZE];
    logic [BYTES-1:0] ref_mask [LQ_SIZE];
    logic [XLEN-1:0] ref_data [LQ_SIZE];
    logic [RD_WIDTH-1:0] ref_rd [LQ_SIZE];
    rob_idx_t ref_rob [LQ_SIZE];
    lq_idx_t rob_slot [2*ROB_SIZE];                 // queue position of each dispatched rob entry.
    lq_idx_t ref_head;
    lq_idx_t ref_tail;
    int errors;
    int checks;

    load_queue DUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Error at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("%s at %0t ns", what, $time);
        end
    endtask

    task automatic random_gap();
        repeat ($urandom % 3) @(posedge clk);
    endtask

    task automatic dispatch_loads(input int n, input rob_idx_t r0, input rob_idx_t r1);
        lq_idx_t pos;
        rob_idx_t rob;
        @(negedge clk);
        check_eq("tail_idx", tail_idx, ref_tail);
        @(posedge clk);
        for (int k = 0; k < n; k++) begin
            rob = (k == 0) ? r0 : r1;
            pos = ref_tail + 4'(k);                 // slot k takes the tail plus k.
            dis[k] <= '{en: 1'b1, rob_idx: rob, lq_idx: pos};
            rob_slot[rob] = pos;
            ref_valid[pos.idx] = 1'b1;
            ref_exec[pos.idx] = 1'b0;
        end
        dis_num <= 2'(n);
        @(posedge clk);
        for (int k = 0; k < DIS_PORTS; k++) begin
            dis[k] <= '0;
        end
        dis_num <= '0;
        ref_tail = ref_tail + 4'(n);
    endtask

    task automatic send_result(input int pipe, input logic miss, input rob_idx_t rob,
                               input logic [RD_WIDTH-1:0] rd, input logic [XLEN-1:0] addr,
                               input logic [BYTES-1:0] mask, input logic [XLEN-1:0] data);
        lq_idx_t pos;
        pos = rob_slot[rob];
        @(posedge clk);
        res[pipe] <= '{en: 1'b1, miss: miss, lq_idx: pos, rob_idx: rob, rd: rd, addr: addr,
                       mask: mask, data: data};
        ref_exec[pos.idx] = 1'b1;
        ref_addr[pos.idx] = addr;
        ref_mask[pos.idx] = mask;
        ref_data[pos.idx] = data;
        ref_rd[pos.idx] = rd;
        ref_rob[pos.idx] = rob;
        @(posedge clk);
        res[pipe] <= '0;
    endtask

    task automatic send_refill(input rob_idx_t rob, input logic [XLEN-1:0] data,
                               input logic [XLEN-1:0] merged_exp);
        lq_idx_t pos;
        logic [XLEN-1:0] merged;
        pos = rob_slot[rob];
        for (int b = 0; b < BYTES; b++) begin
            merged[8*b +: 8] = ref_mask[pos.idx][b] ? ref_data[pos.idx][8*b +: 8]
                                                    : data[8*b +: 8];
        end
        check_eq("vector merged data", merged, merged_exp);
        ref_data[pos.idx] = merged;
        @(posedge clk);
        refill <= '{en: 1'b1, idx: pos.idx, data: data};
        @(posedge clk);
        refill <= '0;
    endtask

    task automatic check_store(input lq_idx_t lq, input logic [XLEN-1:0] addr,
                               input logic [BYTES-1:0] mask, input logic [7:0] exp);
        lq_idx_t pos;
        lq_idx_t found_pos;
        logic [7:0] found;
        logic [3:0] sd;
        logic [3:0] td;
        logic seen;
        int cnt;
        sd = lq - ref_head;
        td = ref_tail - ref_head;
        found = 8'hff;
        found_pos = '0;
        // walk from the youngest down so the last hit is the oldest same-age or younger load.
        for (int i = LQ_SIZE - 1; i >= 0; i--) begin
            pos = ref_head + 4'(i);
            if (i < td && (sd > td || i >= sd) && ref_valid[pos.idx] && ref_exec[pos.idx]
                && ref_addr[pos.idx][XLEN-1:2] == addr[XLEN-1:2]
                && |(ref_mask[pos.idx] & mask)) begin
                found = 8'(ref_rob[pos.idx]);
                found_pos = pos;
            end
        end
        check_eq("vector violation rob", found, exp);
        @(posedge clk);
        store_chk <= '{en: 1'b1, lq_idx: lq, addr: addr, mask: mask};
        @(posedge clk);
        store_chk <= '0;
        cnt = 0;
        seen = 1'b0;
        while (cnt < ((found == 8'hff) ? 4 : 20) && !seen) begin
            @(negedge clk);
            cnt++;
            seen = violation.en;
        end
        if (found == 8'hff) begin
            check_true(!seen, "violation reported for a store with no younger overlapping load");
        end else begin
            check_true(seen, "timeout waiting for a violation report");
            if (seen) begin
                check_eq("violation delay", cnt, 2);
                check_eq("violation.lq_idx", violation.lq_idx, found_pos);
                check_eq("violation.rob_idx", violation.rob_idx, found[4:0]);
                @(negedge clk);
                check_eq("violation.en", violation.en, 1'b0);   // one cycle only.
            end
        end
    endtask

    task automatic commit_loads(input int n);
        lq_idx_t pos;
        @(posedge clk);
        commit_num <= 2'(n);
        @(posedge clk);
        commit_num <= '0;
        for (int i = 0; i < n; i++) begin
            pos = ref_head + 4'(i);
            ref_valid[pos.idx] = 1'b0;
        end
        ref_head = ref_head + 4'(n);
    endtask

    task automatic redirect_to(input rob_idx_t rob);
        lq_idx_t pos;
        lq_idx_t target;
        target = rob_slot[rob];
        @(posedge clk);
        redirect <= 1'b1;
        redirect_rob <= rob;
        @(posedge clk);
        redirect <= 1'b0;
        @(negedge clk);
        check_eq("tail_idx", tail_idx, ref_tail);   // not restored yet.
        @(posedge clk);
        @(negedge clk);
        check_eq("tail_idx", tail_idx, target);
        pos = target;
        for (int i = 0; i < LQ_SIZE && pos != ref_tail; i++) begin
            ref_valid[pos.idx] = 1'b0;
            pos = pos + 4'd1;
        end
        ref_tail = target;
    endtask

    task automatic await_writeback(input logic [7:0] r0, input logic [7:0] r1);
        lq_idx_t p0;
        lq_idx_t p1;
        logic seen;
        int cnt;
        p0 = rob_slot[r0[4:0]];
        p1 = rob_slot[r1[4:0]];
        cnt = 0;
        seen = 1'b0;
        while (cnt < 20 && !seen) begin
            @(negedge clk);
            cnt++;
            seen = wb[0].en || wb[1].en;
        end
        check_true(seen, "timeout waiting for a writeback");
        if (seen) begin
            check_eq("wb[0].en", wb[0].en, 1'b1);
            check_eq("wb[0].rob_idx", wb[0].rob_idx, r0[4:0]);
            check_eq("wb[0].rd", wb[0].rd, ref_rd[p0.idx]);
            check_eq("wb[0].res", wb[0].res, ref_data[p0.idx]);
            check_eq("wb[1].en", wb[1].en, r1 != 8'hff);
            if (r1 != 8'hff) begin
                check_eq("wb[1].rob_idx", wb[1].rob_idx, r1[4:0]);
                check_eq("wb[1].rd", wb[1].rd, ref_rd[p1.idx]);
                check_eq("wb[1].res", wb[1].res, ref_data[p1.idx]);
            end
        end
    endtask

    task automatic watch_no_writeback(input int n);
        repeat (n) begin
            @(negedge clk);
            check_true(!wb[0].en && !wb[1].en, "unexpected writeback on a lane");
        end
    endtask

    initial begin
        int fd;
        string cmd;
        logic [31:0] a, b, c, d, e, f, g;
        void'($urandom(32'hb80e_6199));
        errors = 0;
        checks = 0;
        rst = 1'b1;
        for (int k = 0; k < DIS_PORTS; k++) begin
            dis[k] = '0;
        end
        for (int p = 0; p < LOAD_PIPES; p++) begin
            res[p] = '0;
        end
        dis_num = '0;
        refill = '0;
        store_chk = '0;
        commit_num = '0;
        redirect = 1'b0;
        redirect_rob = '0;
        wb_ready = '1;
        ref_valid = '0;
        ref_exec = '0;
        ref_head = '0;
        ref_tail = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_eq("tail_idx", tail_idx, 4'h0);
        check_eq("wb[0].en", wb[0].en, 1'b0);
        check_eq("wb[1].en", wb[1].en, 1'b0);
        check_eq("violation.en", violation.en, 1'b0);
        fd = $fopen("tests/load_queue_vectors.txt", "r");
        check_true(fd != 0, "cannot open tests/load_queue_vectors.txt");
        if (fd != 0) begin
            while ($fscanf(fd, "%s", cmd) == 1) begin
                case (cmd)
                    "dis": begin
                        void'($fscanf(fd, "%h %h %h", a, b, c));
                        random_gap();
                        dispatch_loads(a, b[4:0], c[4:0]);
                    end
                    "res": begin
                        void'($fscanf(fd, "%h %h %h %h %h %h %h", a, b, c, d, e, f, g));
                        send_result(a, b[0], c[4:0], d[5:0], e, f[3:0], g);
                    end
                    "refill": begin
                        void'($fscanf(fd, "%h %h %h", a, b, c));
                        send_refill(a[4:0], b, c);
                    end
                    "store": begin
                        void'($fscanf(fd, "%h %h %h %h", a, b, c, d));
                        check_store(a[3:0], b, c[3:0], d[7:0]);
                    end
                    "commit": begin
                        void'($fscanf(fd, "%h", a));
                        random_gap();
                        commit_loads(a);
                    end
                    "redirect": begin
                        void'($fscanf(fd, "%h", a));
                        redirect_to(a[4:0]);
                    end
                    "ready": begin
                        void'($fscanf(fd, "%h", a));
                        @(posedge clk);
                        wb_ready <= a[1:0];
                    end
                    "wb": begin
                        void'($fscanf(fd, "%h %h", a, b));
                        await_writeback(a[7:0], b[7:0]);
                    end
                    "nowb": begin
                        void'($fscanf(fd, "%h", a));
                        watch_no_writeback(a);
                    end
                    "idle": begin
                        void'($fscanf(fd, "%h", a));
                        repeat (a) @(posedge clk);
                    end
                    "tail": begin
                        void'($fscanf(fd, "%h", a));
                        @(negedge clk);
                        check_eq("tail_idx", tail_idx, a[3:0]);
                        check_eq("reference tail", ref_tail, a[3:0]);
                    end
                    default: begin
                        if (cmd.getc(0) != "#") begin
                            check_true(1'b0, {"unknown vector command ", cmd});
                        end
                        void'($fgets(cmd, fd));            // skip the rest of the line.
                    end
                endcase
            end
            $fclose(fd);
        end
        @(negedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* logic/load_queue.sv */
`default_nettype none

module load_queue import lsq_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  dis_req_t dis [DIS_PORTS],
    input  logic [$clog2(DIS_PORTS+1)-1:0] dis_num,
    output lq_idx_t tail_idx,
    input  load_res_t res [LOAD_PIPES],
    input  refill_t refill,
    input  store_chk_t store_chk,
    input  logic [$clog2(COMMIT_PORTS+1)-1:0] commit_num,
    input  logic redirect,
    input  rob_idx_t redirect_rob,
    output wb_t wb [LOAD_PIPES],
    input  logic [LOAD_PIPES-1:0] wb_ready,
    output violation_t violation
);

    lq_idx_t head;
    lq_idx_t tail;
    logic redirect_apply;
    lq_idx_t restore_tail;
    logic [LQ_SIZE-1:0] valid;
    logic [LQ_SIZE-1:0] executed;
    logic [LQ_SIZE-1:0] waiting;
    logic [XLEN-1:2] addr [LQ_SIZE];
    logic [BYTES-1:0] mask [LQ_SIZE];
    logic [XLEN-1:0] data [LQ_SIZE];
    entry_meta_t meta [LQ_SIZE];
    logic [LOAD_PIPES-1:0] wb_written;
    logic [LQ_WIDTH-1:0] wb_idx [LOAD_PIPES];

    lq_pointers u_pointers (
        .clk(clk), .rst(rst), .dis(dis), .dis_num(dis_num), .commit_num(commit_num),
        .redirect(redirect), .redirect_rob(redirect_rob), .head(head), .tail(tail),
        .redirect_apply(redirect_apply), .restore_tail(restore_tail)
    );

    lq_entries u_entries (
        .clk(clk), .rst(rst), .tail(tail), .commit_num(commit_num), .head(head),
        .redirect_apply(redirect_apply), .restore_tail(restore_tail), .dis(dis),
        .res(res), .refill(refill), .wb_written(wb_written), .wb_idx(wb_idx),
        .valid(valid), .executed(executed), .waiting(waiting),
        .addr(addr), .mask(mask), .data(data), .meta(meta)
    );

    lq_violation_check u_violation_check (
        .clk(clk), .rst(rst), .store_chk(store_chk), .head(head), .tail(tail),
        .valid(valid), .executed(executed), .addr(addr), .mask(mask), .meta(meta),
        .violation(violation)
    );

    lq_writeback_select u_writeback_select (
        .clk(clk), .rst(rst), .waiting(waiting), .data(data), .meta(meta),
        .wb_ready(wb_ready), .wb_written(wb_written), .wb_idx(wb_idx), .wb(wb)
    );

    assign tail_idx = tail;             // next free slot for dispatch slot 0.

endmodule

`default_nettype wire

/* logic/lq_writeback_select.sv */
`default_nettype none

module lq_writeback_select import lsq_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic [LQ_SIZE-1:0] waiting,
    input  logic [XLEN-1:0] data [LQ_SIZE],
    input  entry_meta_t meta [LQ_SIZE],
    input  logic [LOAD_PIPES-1:0] wb_ready,
    output logic [LOAD_PIPES-1:0] wb_written,
    output logic [LQ_WIDTH-1:0] wb_idx [LOAD_PIPES],
    output wb_t wb [LOAD_PIPES]
);

    logic [LOAD_PIPES-1:0] lane_en;
    logic [LOAD_PIPES-1:0] wb_en_q;
    logic [XLEN-1:0] res_q [LOAD_PIPES];
    entry_meta_t meta_q [LOAD_PIPES];

    // lane 0 takes the lowest waiting index and lane 1 the highest.
    always_comb begin
        wb_idx[0] = '0;
        wb_idx[1] = '0;
        for (int i = LQ_SIZE - 1; i >= 0; i--) begin
            if (waiting[i]) begin
                wb_idx[0] = LQ_WIDTH'(i);
            end
        end
        for (int i = 0; i < LQ_SIZE; i++) begin
            if (waiting[i]) begin
                wb_idx[1] = LQ_WIDTH'(i);
            end
        end
    end

    assign lane_en[0] = |waiting;
    assign lane_en[1] = (|waiting) && (wb_idx[1] != wb_idx[0]);   // one waiting load uses lane 0 only.
    assign wb_written = lane_en & wb_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_en_q <= '0;
        end else begin
            wb_en_q <= wb_written;
        end
    end

    for (genvar l = 0; l < LOAD_PIPES; l++) begin : g_lane
        always_ff @(posedge clk) begin
            if (wb_written[l]) begin
                res_q[l] <= data[wb_idx[l]];
                meta_q[l] <= meta[wb_idx[l]];
            end
        end

        assign wb[l] = '{en: wb_en_q[l], rob_idx: meta_q[l].rob_idx, rd: meta_q[l].rd,
                         res: res_q[l]};
    end

endmodule

`default_nettype wire

/* logic/lq_violation_check.sv */
`default_nettype none

module lq_violation_check import lsq_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  store_chk_t store_chk,
    input  lq_idx_t head,
    input  lq_idx_t tail,
    input  logic [LQ_SIZE-1:0] valid,
    input  logic [LQ_SIZE-1:0] executed,
    input  logic [XLEN-1:2] addr [LQ_SIZE],
    input  logic [BYTES-1:0] mask [LQ_SIZE],
    input  entry_meta_t meta [LQ_SIZE],
    output violation_t violation
);

    logic [LQ_WIDTH:0] store_dist;
    logic [LQ_WIDTH:0] tail_dist;
    lq_idx_t age_lo;
    logic [LQ_SIZE-1:0] age_mask;
    logic [LQ_SIZE-1:0] match;
    logic [LQ_SIZE-1:0] match_q;
    lq_idx_t lo_q;
    logic [LQ_WIDTH-1:0] sel;
    lq_idx_t pick;
    logic viol_en;
    lq_idx_t viol_idx;
    rob_idx_t viol_rob;

    // A store whose slot has already fallen behind the head is older than every live load.
    assign store_dist = store_chk.lq_idx - head;
    assign tail_dist = tail - head;
    assign age_lo = (store_dist > tail_dist) ? head : store_chk.lq_idx;
    assign age_mask = range_mask(age_lo, tail);

    always_comb begin
        for (int j = 0; j < LQ_SIZE; j++) begin
            match[j] = store_chk.en && valid[j] && executed[j] && age_mask[j]
                       && (addr[j] == store_chk.addr[XLEN-1:2])
                       && (|(mask[j] & store_chk.mask));
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            match_q <= '0;
        end else begin
            match_q <= match;
        end
    end

    always_ff @(posedge clk) begin
        lo_q <= age_lo;
    end

    // Search upward from the store's slot so the first hit is the oldest load.
    always_comb begin
        sel = '0;
        for (int k = LQ_SIZE - 1; k >= 0; k--) begin
            if (match_q[LQ_WIDTH'(lo_q.idx + k)]) begin
                sel = LQ_WIDTH'(k);
            end
        end
        pick = lo_q + (LQ_WIDTH+1)'(sel);                  // the carry fixes the wrap bit.
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            viol_en <= 1'b0;
        end else begin
            viol_en <= |match_q;
        end
    end

    always_ff @(posedge clk) begin
        viol_idx <= pick;
        viol_rob <= meta[pick.idx].rob_idx;
    end

    assign violation = '{en: viol_en, lq_idx: viol_idx, rob_idx: viol_rob};

endmodule

`default_nettype wire

/* logic/lq_entries.sv */
`default_nettype none

module lq_entries import lsq_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  lq_idx_t tail,
    input  logic [$clog2(COMMIT_PORTS+1)-1:0] commit_num,
    input  lq_idx_t head,
    input  logic redirect_apply,
    input  lq_idx_t restore_tail,
    input  dis_req_t dis [DIS_PORTS],
    input  load_res_t res [LOAD_PIPES],
    input  refill_t refill,
    input  logic [LOAD_PIPES-1:0] wb_written,
    input  logic [LQ_WIDTH-1:0] wb_idx [LOAD_PIPES],
    output logic [LQ_SIZE-1:0] valid,
    output logic [LQ_SIZE-1:0] executed,
    output logic [LQ_SIZE-1:0] waiting,
    output logic [XLEN-1:2] addr [LQ_SIZE],
    output logic [BYTES-1:0] mask [LQ_SIZE],
    output logic [XLEN-1:0] data [LQ_SIZE],
    output entry_meta_t meta [LQ_SIZE]
);

    logic [LQ_SIZE-1:0] miss;
    logic [LQ_SIZE-1:0] data_valid;
    logic [LQ_SIZE-1:0] written;
    logic [LQ_SIZE-1:0] dis_mask;
    logic [LQ_SIZE-1:0] commit_mask;
    logic [LQ_SIZE-1:0] squash_mask;
    logic [XLEN-1:0] refill_merged;

    always_comb begin
        dis_mask = '0;
        commit_mask = '0;
        for (int k = 0; k < DIS_PORTS; k++) begin
            if (dis[k].en && !redirect_apply) begin
                dis_mask[dis[k].lq_idx.idx] = 1'b1;
            end
        end
        for (int i = 0; i < COMMIT_PORTS; i++) begin
            if (i < commit_num) begin
                commit_mask[LQ_WIDTH'(head.idx + i)] = 1'b1;
            end
        end
    end

    assign squash_mask = redirect_apply ? range_mask(restore_tail, tail) : '0;

    // Bytes the load already read keep their data, the rest come from the refill.
    always_comb begin
        for (int b = 0; b < BYTES; b++) begin
            refill_merged[8*b +: 8] = mask[refill.idx][b] ? data[refill.idx][8*b +: 8]
                                                          : refill.data[8*b +: 8];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;
            executed <= '0;
            miss <= '0;
            data_valid <= '0;
            written <= '0;
        end else begin
            valid <= (valid & ~commit_mask & ~squash_mask) | dis_mask;
            for (int i = 0; i < LQ_SIZE; i++) begin
                if (dis_mask[i]) begin
                    executed[i] <= 1'b0;
                    miss[i] <= 1'b0;
                    data_valid[i] <= 1'b0;
                    written[i] <= 1'b0;
                end
            end
            for (int p = 0; p < LOAD_PIPES; p++) begin
                if (res[p].en) begin
                    executed[res[p].lq_idx.idx] <= 1'b1;
                    miss[res[p].lq_idx.idx] <= res[p].miss;
                    data_valid[res[p].lq_idx.idx] <= ~res[p].miss;
                    written[res[p].lq_idx.idx] <= ~res[p].miss;   // a hit is written back by the pipe.
                end
            end
            for (int l = 0; l < LOAD_PIPES; l++) begin
                if (wb_written[l]) begin
                    written[wb_idx[l]] <= 1'b1;
                end
            end
            if (refill.en) begin
                data_valid[refill.idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < LOAD_PIPES; p++) begin
            if (res[p].en) begin
                addr[res[p].lq_idx.idx] <= res[p].addr[XLEN-1:2];
                mask[res[p].lq_idx.idx] <= res[p].mask;
                data[res[p].lq_idx.idx] <= res[p].data;
                meta[res[p].lq_idx.idx] <= '{rob_idx: res[p].rob_idx, rd: res[p].rd};
            end
        end
        if (refill.en) begin
            data[refill.idx] <= refill_merged;
        end
    end

    assign waiting = valid & miss & data_valid & ~written;

endmodule

`default_nettype wire

/* logic/lq_pointers.sv */
`default_nettype none

module lq_pointers import lsq_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  dis_req_t dis [DIS_PORTS],
    input  logic [$clog2(DIS_PORTS+1)-1:0] dis_num,
    input  logic [$clog2(COMMIT_PORTS+1)-1:0] commit_num,
    input  logic redirect,
    input  rob_idx_t redirect_rob,
    output lq_idx_t head,
    output lq_idx_t tail,
    output logic redirect_apply,
    output lq_idx_t restore_tail
);

    lq_idx_t restore_table [ROB_SIZE];
    lq_idx_t head_next;
    lq_idx_t tail_next;

    // The wrap bit sits right above the index and the size is a power of two,
    // so a plain add carries into it when the pointer passes the last entry.
    assign head_next = head + (LQ_WIDTH+1)'(commit_num);
    assign tail_next = tail + (LQ_WIDTH+1)'(dis_num);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            redirect_apply <= 1'b0;
        end else begin
            head <= head_next;
            redirect_apply <= redirect;             // second edge of the redirect.
            if (redirect_apply) begin
                tail <= restore_tail;               // dispatch in this cycle is dropped.
            end else begin
                tail <= tail_next;
            end
        end
    end

    // each dispatched load records its slot under its rob index.
    always_ff @(posedge clk) begin
        for (int k = 0; k < DIS_PORTS; k++) begin
            if (dis[k].en && !redirect_apply) begin
                restore_table[dis[k].rob_idx.idx] <= dis[k].lq_idx;
            end
        end
    end

    // The redirecting load's own slot becomes the new tail, so it is squashed as well.
    always_ff @(posedge clk) begin
        if (redirect) begin
            restore_tail <= restore_table[redirect_rob.idx];
        end
    end

endmodule

`default_nettype wire

/* logic/lsq_pkg.sv */
`default_nettype none

package lsq_pkg;

    localparam int LQ_SIZE = 8;
    localparam int LQ_WIDTH = 3;
    localparam int ROB_SIZE = 16;
    localparam int ROB_WIDTH = 4;
    localparam int LOAD_PIPES = 2;
    localparam int DIS_PORTS = 2;
    localparam int COMMIT_PORTS = 2;
    localparam int XLEN = 32;
    localparam int BYTES = 4;
    localparam int RD_WIDTH = 6;

    typedef struct packed {
        logic dir;                      // flips each time the pointer wraps.
        logic [LQ_WIDTH-1:0] idx;
    } lq_idx_t;

    typedef struct packed {
        logic dir;
        logic [ROB_WIDTH-1:0] idx;
    } rob_idx_t;

    typedef struct packed {
        logic en;
        rob_idx_t rob_idx;
        lq_idx_t lq_idx;
    } dis_req_t;

    typedef struct packed {
        logic en;
        logic miss;
        lq_idx_t lq_idx;
        rob_idx_t rob_idx;
        logic [RD_WIDTH-1:0] rd;
        logic [XLEN-1:0] addr;          // only bits above the byte offset are compared.
        logic [BYTES-1:0] mask;
        logic [XLEN-1:0] data;
    } load_res_t;

    typedef struct packed {
        logic en;
        logic [LQ_WIDTH-1:0] idx;
        logic [XLEN-1:0] data;
    } refill_t;

    typedef struct packed {
        logic en;
        lq_idx_t lq_idx;                // tail at the time the store was dispatched.
        logic [XLEN-1:0] addr;
        logic [BYTES-1:0] mask;
    } store_chk_t;

    typedef struct packed {
        logic en;
        rob_idx_t rob_idx;
        logic [RD_WIDTH-1:0] rd;
        logic [XLEN-1:0] res;
    } wb_t;

    typedef struct packed {
        logic en;
        lq_idx_t lq_idx;
        rob_idx_t rob_idx;
    } violation_t;

    typedef struct packed {
        rob_idx_t rob_idx;
        logic [RD_WIDTH-1:0] rd;
    } entry_meta_t;

    // One bit per entry from lo up to but not including hi, following the wrap bits.
    function automatic logic [LQ_SIZE-1:0] range_mask(input lq_idx_t lo, input lq_idx_t hi);
        logic [LQ_SIZE-1:0] m;
        for (int i = 0; i < LQ_SIZE; i++) begin
            if (lo.dir == hi.dir) begin
                m[i] = (i >= lo.idx) && (i < hi.idx);
            end else begin
                m[i] = (i >= lo.idx) || (i < hi.idx);
            end
        end
        return m;
    endfunction

endpackage

`default_nettype wire
